//--- compile.f
+incdir+verification
src/video_ctrl_pkg.sv
src/host_cmd_regs.sv
src/umuldiv.sv
src/scaler_window.sv
src/sync_polarity.sv
src/video_ctrl_top.sv
verification/tb_video_ctrl.sv

//--- src/host_cmd_regs.sv
////////////////////////////////////////
// Wishbone classic slave taking the host command stream
// Adr 0 selects a command and adr 1 feeds its parameter words
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module host_cmd_regs (
	input  wire                         clk_sys,
	input  wire                         resetd,
	input  wire video_ctrl_pkg::wb_req_t i_wb,
	output video_ctrl_pkg::wb_rsp_t     o_wb,
	output video_ctrl_pkg::frame_size_t o_size,
	output video_ctrl_pkg::scale_lim_t  o_lim,
	output video_ctrl_pkg::ar_pair_t    o_ar1,
	output video_ctrl_pkg::ar_pair_t    o_ar2
);
	import video_ctrl_pkg::*;

	logic       ack_q;
	cmd_t       cmd_q;
	logic [3:0] idx_q;
	logic       access;
	logic       wr_cmd;
	logic       wr_par;
	word_t      rd_dat;

	// One transfer per stb as ack drops before the next sample
	assign access = i_wb.cyc & i_wb.stb & ~ack_q;
	assign wr_cmd = access & i_wb.we & ~i_wb.adr;
	assign wr_par = access & i_wb.we & i_wb.adr;

	// Status word with the index above the active command
	assign rd_dat = {4'b0000, idx_q, cmd_q};

	assign o_wb = '{ack: ack_q, dat: rd_dat};

	////////////////////////////////////////
	// Handshake and command state

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			ack_q <= 1'b0;
			cmd_q <= '0;
			idx_q <= '0;
		end else begin
			ack_q <= access;
			if (wr_cmd) begin
				cmd_q <= i_wb.dat[7:0];
				idx_q <= '0;
			end else if (wr_par && idx_q != 4'hF) begin
				idx_q <= idx_q + 4'd1;
			end
		end
	end

	////////////////////////////////////////
	// Parameter decode

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			o_size <= '{width: DEF_WIDTH, height: DEF_HEIGHT};
			o_lim  <= '0;
			o_ar1  <= '0;
			o_ar2  <= '0;
		end else if (wr_par) begin
			case (cmd_q)
				CMD_FRAME_SIZE: begin
					// Porch and sync words are dropped
					if (idx_q == 4'd0) begin
						o_size.width <= i_wb.dat[11:0];
					end
					if (idx_q == 4'd4) begin
						o_size.height <= i_wb.dat[11:0];
					end
				end
				CMD_VSET: begin
					o_lim.vset <= i_wb.dat[11:0];
				end
				CMD_HSET: begin
					o_lim.freescale <= i_wb.dat[15];
					o_lim.hset      <= i_wb.dat[11:0];
				end
				CMD_CUSTOM_AR: begin
					case (idx_q)
						4'd0: o_ar1.x <= i_wb.dat[12:0];
						4'd1: o_ar1.y <= i_wb.dat[12:0];
						4'd2: o_ar2.x <= i_wb.dat[12:0];
						4'd3: o_ar2.y <= i_wb.dat[12:0];
						default: begin
						end
					endcase
				end
				default: begin
				end
			endcase
		end
	end

	// Host drops stb while ack is high so a held stb never repeats a write
	a_host_stb_drop: assert property (
		@(posedge clk_sys) disable iff (resetd)
		o_wb.ack |-> !i_wb.stb
	);

endmodule

`default_nettype wire

//--- src/scaler_window.sv
////////////////////////////////////////
// Free-running window calculator; each pass snapshots the
// settings and produces a centred output window
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module scaler_window (
	input  wire                              clk_sys,
	input  wire                              resetd,
	input  wire video_ctrl_pkg::frame_size_t i_size,
	input  wire video_ctrl_pkg::scale_lim_t  i_lim,
	input  wire video_ctrl_pkg::ar_pair_t    i_ar,
	input  wire video_ctrl_pkg::ar_pair_t    i_ar1,
	input  wire video_ctrl_pkg::ar_pair_t    i_ar2,
	output video_ctrl_pkg::window_t          o_win
);
	import video_ctrl_pkg::*;

	win_state_e  state_q;
	ar_pair_t    ar_pick;
	dim_t        use_w;
	dim_t        use_h;
	logic        direct;
	frame_size_t size_q;
	dim_t        use_w_q;
	dim_t        use_h_q;
	dim_t        run_x;
	dim_t        run_y;
	dim_t        tgt_w;
	dim_t        tgt_h;
	dim_t        h_off;
	dim_t        v_off;
	logic        md_start;
	logic        md_busy;
	dim_t        md_mul1;
	dim_t        md_mul2;
	dim_t        md_div;
	dim_t        md_result;

	// Limits only apply when below the frame size
	assign use_w = (i_lim.hset != '0 && i_lim.hset < i_size.width) ? i_lim.hset : i_size.width;
	assign use_h = (i_lim.vset != '0 && i_lim.vset < i_size.height) ? i_lim.vset : i_size.height;

	// Y of zero makes X a custom ratio selector
	always_comb begin
		ar_pick = i_ar;
		if (i_ar.y == '0) begin
			if (i_ar.x == 13'd1) begin
				ar_pick = i_ar1;
			end else if (i_ar.x == 13'd2) begin
				ar_pick = i_ar2;
			end else begin
				ar_pick = '0;
			end
		end
	end

	assign direct = ar_pick.x[12] | ar_pick.y[12];

	assign h_off = (size_q.width - tgt_w) >> 1;
	assign v_off = (size_q.height - tgt_h) >> 1;

	////////////////////////////////////////
	// Multiply-divide operands

	assign md_start = (state_q == WS_MUL_W) || (state_q == WS_MUL_H);
	assign md_mul1  = (state_q == WS_MUL_W) ? use_h_q : use_w_q;
	assign md_mul2  = (state_q == WS_MUL_W) ? run_x : run_y;
	assign md_div   = (state_q == WS_MUL_W) ? run_y : run_x;

	umuldiv umuldiv_inst (
		.clk_sys  (clk_sys),
		.resetd   (resetd),
		.i_start  (md_start),
		.i_mul1   (md_mul1),
		.i_mul2   (md_mul2),
		.i_div    (md_div),
		.o_busy   (md_busy),
		.o_result (md_result)
	);

	////////////////////////////////////////
	// Sequencer

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			state_q <= WS_SELECT;
			o_win   <= '0;
		end else begin
			case (state_q)
				WS_SELECT: begin
					size_q  <= i_size;
					use_w_q <= use_w;
					use_h_q <= use_h;
					run_x   <= ar_pick.x[11:0];
					run_y   <= ar_pick.y[11:0];
					if (i_lim.freescale || ar_pick.x[11:0] == '0 || ar_pick.y[11:0] == '0) begin
						tgt_w   <= use_w;
						tgt_h   <= use_h;
						state_q <= WS_CLAMP;
					end else if (direct) begin
						tgt_w   <= ar_pick.x[11:0];
						tgt_h   <= ar_pick.y[11:0];
						state_q <= WS_CLAMP;
					end else begin
						state_q <= WS_MUL_W;
					end
				end
				WS_MUL_W: state_q <= WS_WAIT_W;
				WS_WAIT_W: begin
					if (!md_busy) begin
						tgt_w   <= md_result;
						state_q <= WS_MUL_H;
					end
				end
				WS_MUL_H: state_q <= WS_WAIT_H;
				WS_WAIT_H: begin
					if (!md_busy) begin
						tgt_h   <= md_result;
						state_q <= WS_CLAMP;
					end
				end
				WS_CLAMP: begin
					tgt_w   <= (tgt_w > use_w_q) ? use_w_q : tgt_w;
					tgt_h   <= (tgt_h > use_h_q) ? use_h_q : tgt_h;
					state_q <= WS_CENTER;
				end
				WS_CENTER: begin
					o_win.hmin <= h_off;
					o_win.hmax <= h_off + tgt_w - 12'd1;
					o_win.vmin <= v_off;
					o_win.vmax <= v_off + tgt_h - 12'd1;
					state_q    <= WS_SELECT;
				end
				default: state_q <= WS_SELECT;
			endcase
		end
	end

	a_win_order: assert property (
		@(posedge clk_sys) disable iff (resetd)
		(state_q == WS_CENTER && tgt_w != '0) |=> (o_win.hmin <= o_win.hmax)
	);

endmodule

`default_nettype wire

//--- src/sync_polarity.sv
////////////////////////////////////////
// Turns a sync of either polarity into a short active-high pulse
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module sync_polarity (
	input  wire  clk_sys,
	input  wire  resetd,
	input  wire  i_sync,
	output logic o_sync
);
	import video_ctrl_pkg::*;

	logic                  s1;
	logic                  s2;
	logic                  pol;
	logic [SYNC_CNT_W-1:0] cnt;
	logic [SYNC_CNT_W-1:0] len_hi;
	logic [SYNC_CNT_W-1:0] len_lo;

	assign o_sync = i_sync ^ pol;

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			s1     <= 1'b0;
			s2     <= 1'b0;
			cnt    <= '0;
			len_hi <= '0;
			len_lo <= '0;
			pol    <= 1'b0;
		end else begin
			s1 <= i_sync;
			s2 <= s1;
			// Rising edge ends a low phase, falling edge a high phase
			if (s1 & ~s2) begin
				len_lo <= cnt;
			end
			if (~s1 & s2) begin
				len_hi <= cnt;
			end
			if (s1 != s2) begin
				cnt <= '0;
			end else if (cnt != '1) begin
				cnt <= cnt + 1'b1;
			end
			pol <= len_hi > len_lo;
		end
	end

endmodule

`default_nettype wire

//--- src/umuldiv.sv
////////////////////////////////////////
// Sequential mul1*mul2/div, one quotient bit per clock
// Result holds after busy falls until the next start
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module umuldiv (
	input  wire                       clk_sys,
	input  wire                       resetd,
	input  wire                       i_start,
	input  wire video_ctrl_pkg::dim_t i_mul1,
	input  wire video_ctrl_pkg::dim_t i_mul2,
	input  wire video_ctrl_pkg::dim_t i_div,
	output logic                      o_busy,
	output video_ctrl_pkg::dim_t      o_result
);
	import video_ctrl_pkg::*;

	logic [$clog2(MULDIV_STEPS + 1)-1:0] step_q;
	dim_t                                mul1_q;
	dim_t                                mul2_q;
	dim_t                                div_q;
	dim_t                                rem_q;
	logic [MULDIV_STEPS-1:0]             quo_q;
	logic [12:0]                         rem_sh;
	logic [13:0]                         trial;

	// Restoring step: shift in next dividend bit, try subtract
	assign rem_sh = {rem_q, quo_q[MULDIV_STEPS-1]};
	assign trial  = {1'b0, rem_sh} - {2'b00, div_q};

	// Clip anything wider than 12 bits
	assign o_result = (|quo_q[MULDIV_STEPS-1:$bits(dim_t)]) ? '1 : quo_q[$bits(dim_t)-1:0];

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			o_busy <= 1'b0;
			step_q <= '0;
		end else if (!o_busy) begin
			if (i_start) begin
				o_busy <= 1'b1;
				step_q <= '0;
			end
		end else begin
			step_q <= step_q + 1'b1;
			if (int'(step_q) == MULDIV_STEPS) begin
				o_busy <= 1'b0;
			end
		end
	end

	// Datapath
	always_ff @(posedge clk_sys) begin
		if (!o_busy && i_start) begin
			mul1_q <= i_mul1;
			mul2_q <= i_mul2;
			div_q  <= i_div;
		end else if (o_busy) begin
			if (step_q == '0) begin
				// Full product goes into the dividend register
				quo_q <= mul1_q * mul2_q;
				rem_q <= '0;
			end else if (!trial[13]) begin
				rem_q <= trial[11:0];
				quo_q <= {quo_q[MULDIV_STEPS-2:0], 1'b1};
			end else begin
				rem_q <= rem_sh[11:0];
				quo_q <= {quo_q[MULDIV_STEPS-2:0], 1'b0};
			end
		end
	end

	a_no_start_busy: assert property (
		@(posedge clk_sys) disable iff (resetd)
		i_start |-> !o_busy
	);

	a_div_nonzero: assert property (
		@(posedge clk_sys) disable iff (resetd)
		(i_start && !o_busy) |-> (i_div != '0)
	);

endmodule

`default_nettype wire

//--- src/video_ctrl_pkg.sv
////////////////////////////////////////
// Types, command codes and reset values shared by the scaler
// control block; modules take it by wildcard import
////////////////////////////////////////
`default_nettype none

package video_ctrl_pkg;

	// Widths with a meaning
	typedef logic [11:0] dim_t;
	// Bit 12 marks a direct size, low 12 bits hold the value
	typedef logic [12:0] ar_t;
	typedef logic [7:0]  cmd_t;
	typedef logic [15:0] word_t;

	// Host command codes
	localparam cmd_t CMD_FRAME_SIZE = 8'h20;
	localparam cmd_t CMD_VSET       = 8'h27;
	localparam cmd_t CMD_HSET       = 8'h37;
	localparam cmd_t CMD_CUSTOM_AR  = 8'h3A;

	// 1920x1080 output after reset
	localparam dim_t DEF_WIDTH  = 12'd1920;
	localparam dim_t DEF_HEIGHT = 12'd1080;

	localparam int MULDIV_STEPS = 24;
	localparam int SYNC_CNT_W   = 16;

	////////////////////////////////////////
	// Bundles

	typedef struct packed {
		logic  cyc;
		logic  stb;
		logic  we;
		logic  adr;
		word_t dat;
	} wb_req_t;

	typedef struct packed {
		logic  ack;
		word_t dat;
	} wb_rsp_t;

	typedef struct packed {
		dim_t width;
		dim_t height;
	} frame_size_t;

	typedef struct packed {
		dim_t vset;
		dim_t hset;
		logic freescale;
	} scale_lim_t;

	typedef struct packed {
		ar_t x;
		ar_t y;
	} ar_pair_t;

	typedef struct packed {
		dim_t hmin;
		dim_t hmax;
		dim_t vmin;
		dim_t vmax;
	} window_t;

	// Window calculator sequence
	typedef enum logic [2:0] {
		WS_SELECT,
		WS_MUL_W,
		WS_WAIT_W,
		WS_MUL_H,
		WS_WAIT_H,
		WS_CLAMP,
		WS_CENTER
	} win_state_e;

endpackage

`default_nettype wire

//--- src/video_ctrl_top.sv
////////////////////////////////////////
// Scaler control top: command registers, window calculator
// and polarity fix for both syncs
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module video_ctrl_top (
	input  wire                              clk_sys,
	input  wire                              resetd,
	input  wire video_ctrl_pkg::wb_req_t     i_wb,
	output wire video_ctrl_pkg::wb_rsp_t     o_wb,
	input  wire video_ctrl_pkg::ar_pair_t    i_ar,
	output wire video_ctrl_pkg::window_t     o_win,
	input  wire                              i_hs,
	input  wire                              i_vs,
	output wire                              o_hs,
	output wire                              o_vs
);
	import video_ctrl_pkg::*;

	wire frame_size_t size;
	wire scale_lim_t  lim;
	wire ar_pair_t    ar1;
	wire ar_pair_t    ar2;

	host_cmd_regs host_cmd_regs_inst (
		.clk_sys (clk_sys),
		.resetd  (resetd),
		.i_wb    (i_wb),
		.o_wb    (o_wb),
		.o_size  (size),
		.o_lim   (lim),
		.o_ar1   (ar1),
		.o_ar2   (ar2)
	);

	scaler_window scaler_window_inst (
		.clk_sys (clk_sys),
		.resetd  (resetd),
		.i_size  (size),
		.i_lim   (lim),
		.i_ar    (i_ar),
		.i_ar1   (ar1),
		.i_ar2   (ar2),
		.o_win   (o_win)
	);

	// One fixer per sync
	sync_polarity sync_fix_h (
		.clk_sys (clk_sys),
		.resetd  (resetd),
		.i_sync  (i_hs),
		.o_sync  (o_hs)
	);

	sync_polarity sync_fix_v (
		.clk_sys (clk_sys),
		.resetd  (resetd),
		.i_sync  (i_vs),
		.o_sync  (o_vs)
	);

endmodule

`default_nettype wire

//--- verification/tb_video_ctrl_vectors.svh
////////////////////////////////////////
// Window test rows and the expected-window model,
// included inside the testbench module
////////////////////////////////////////
`ifndef TB_VIDEO_CTRL_VECTORS_SVH
`define TB_VIDEO_CTRL_VECTORS_SVH

typedef struct packed {
	dim_t     width;
	dim_t     height;
	dim_t     vset;
	dim_t     hset;
	logic     freescale;
	ar_pair_t ar1;
	ar_pair_t ar2;
	ar_pair_t ar;
} vec_t;

localparam int N_VEC = 11;

// Rows start from the default frame with no limits
function automatic vec_t vec_row(input int i);
	vec_t v;
	v = '{width: 12'd1920, height: 12'd1080, default: '0};
	v.ar1 = '{x: 13'd21, y: 13'd9};
	v.ar2 = '{x: 13'd5, y: 13'd4};
	case (i)
		0: v.ar = '{x: 13'd4, y: 13'd3};
		1: v.ar = '{x: 13'd16, y: 13'd9};
		2: begin
			v.width  = 12'd1280;
			v.height = 12'd720;
			v.vset   = 12'd600;
			v.ar     = '{x: 13'd4, y: 13'd3};
		end
		3: begin
			v.hset = 12'd1600;
			v.vset = 12'd900;
			v.ar   = '{x: 13'd16, y: 13'd9};
		end
		4: begin
			v.hset      = 12'd1280;
			v.freescale = 1'b1;
			v.ar        = '{x: 13'd4, y: 13'd3};
		end
		// Direct 800x600
		5: v.ar = '{x: 13'h1320, y: 13'h1258};
		6: v.ar = '{x: 13'd1, y: 13'd0};
		7: v.ar = '{x: 13'd2, y: 13'd0};
		8: v.ar = '{x: 13'd3, y: 13'd0};
		9: begin
			v.width  = 12'd1280;
			v.height = 12'd1024;
			v.ar2    = '{x: 13'h1400, y: 13'h1300};
			v.ar     = '{x: 13'd2, y: 13'd0};
		end
		// Width quotient far above 12 bits
		default: begin
			v.width  = 12'd3840;
			v.height = 12'd2160;
			v.ar     = '{x: 13'd4000, y: 13'd2};
		end
	endcase
	return v;
endfunction

function automatic window_t ref_window(input vec_t v);
	ar_pair_t    a;
	dim_t        uw;
	dim_t        uh;
	dim_t        tw;
	dim_t        th;
	logic [23:0] q;
	window_t     w;
	uw = (v.hset != 12'd0 && v.hset < v.width) ? v.hset : v.width;
	uh = (v.vset != 12'd0 && v.vset < v.height) ? v.vset : v.height;
	if (v.ar.y != 13'd0) begin
		a = v.ar;
	end else if (v.ar.x == 13'd1) begin
		a = v.ar1;
	end else if (v.ar.x == 13'd2) begin
		a = v.ar2;
	end else begin
		a = '0;
	end
	if (v.freescale || a.x[11:0] == 12'd0 || a.y[11:0] == 12'd0) begin
		tw = uw;
		th = uh;
	end else if (a.x[12] || a.y[12]) begin
		tw = a.x[11:0];
		th = a.y[11:0];
	end else begin
		// Product over ratio, clipped to 12 bits
		q  = (24'(uh) * 24'(a.x[11:0])) / 24'(a.y[11:0]);
		tw = (q > 24'd4095) ? 12'hFFF : q[11:0];
		q  = (24'(uw) * 24'(a.y[11:0])) / 24'(a.x[11:0]);
		th = (q > 24'd4095) ? 12'hFFF : q[11:0];
	end
	if (tw > uw) begin
		tw = uw;
	end
	if (th > uh) begin
		th = uh;
	end
	w.hmin = (v.width - tw) >> 1;
	w.hmax = w.hmin + tw - 12'd1;
	w.vmin = (v.height - th) >> 1;
	w.vmax = w.vmin + th - 12'd1;
	return w;
endfunction

`endif

//--- verification/tb_video_ctrl.sv
////////////////////////////////////////
// Testbench for the scaler control top: Wishbone command
// writes, window checks against a model, sync polarity
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tb_video_ctrl;
	import video_ctrl_pkg::*;

	`include "tb_video_ctrl_vectors.svh"

	localparam int RESET_CYCLES  = 16;
	localparam int SETTLE_CYCLES = 116;
	localparam int N_RAND        = 6;
	// Settle time, margin and about twenty two-cycle bus accesses
	localparam int ROW_CYCLES    = SETTLE_CYCLES + 20 + 20 * 3;
	localparam int HS_PERIOD     = 40;
	localparam int HS_LOW        = 6;
	localparam int VS_PERIOD     = 60;
	localparam int VS_HIGH       = 10;
	localparam int SYNC_CYCLES   = 8 * VS_PERIOD;
	localparam int WATCHDOG_CYCLES = RESET_CYCLES + (N_VEC + N_RAND + 3) * ROW_CYCLES
		+ SYNC_CYCLES;

	logic        clk_sys;
	logic        resetd;
	wb_req_t     wb_req;
	wb_rsp_t     wb_rsp;
	ar_pair_t    ar_in;
	window_t     win;
	logic        hs_in;
	logic        vs_in;
	logic        hs_out;
	logic        vs_out;
	logic [31:0] rng_state = 32'd53393;

	video_ctrl_top video_ctrl_top_inst (
		.clk_sys (clk_sys),
		.resetd  (resetd),
		.i_wb    (wb_req),
		.o_wb    (wb_rsp),
		.i_ar    (ar_in),
		.o_win   (win),
		.i_hs    (hs_in),
		.i_vs    (vs_in),
		.o_hs    (hs_out),
		.o_vs    (vs_out)
	);

	initial begin
		clk_sys = 1'b0;
		forever #5 clk_sys = ~clk_sys;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk_sys);
		$display("Timeout: test sequence did not end within %0d cycles", WATCHDOG_CYCLES);
		$display("Simulation failed");
		$fatal(1, "watchdog expired");
	end

	function automatic logic [31:0] xorshift_next();
		rng_state = rng_state ^ (rng_state << 13);
		rng_state = rng_state ^ (rng_state >> 17);
		rng_state = rng_state ^ (rng_state << 5);
		return rng_state;
	endfunction

	task automatic check_eq(input logic [63:0] got, input logic [63:0] exp, input string what);
		if (got !== exp) begin
			$display("CHECK FAILED at %0t ns: %s, got 0x%0h, expected 0x%0h",
				$time, what, got, exp);
			$display("Simulation failed");
			$fatal(1, "stopping at first mismatch");
		end
	endtask

	task automatic wait_cycles(input int n);
		repeat (n) @(posedge clk_sys);
		#1;
	endtask

	////////////////////////////////////////
	// Wishbone classic host

	// Entered 1 ns after a rising edge, leaves the same way
	task automatic wb_access(input logic we, input logic adr, input word_t dat,
		output word_t rd);
		int waited;
		wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: dat};
		waited = 0;
		do begin
			@(posedge clk_sys);
			#1;
			waited++;
		end while (!wb_rsp.ack && waited < 4);
		check_eq(64'(waited), 64'd1, "ack one cycle after stb");
		rd = wb_rsp.dat;
		wb_req = '0;
		@(posedge clk_sys);
		#1;
		check_eq(64'(wb_rsp.ack), 64'd0, "ack lasts one cycle");
	endtask

	task automatic wb_write(input logic adr, input word_t dat);
		word_t unused;
		wb_access(1'b1, adr, dat, unused);
	endtask

	task automatic wb_read(input logic adr, output word_t rd);
		wb_access(1'b0, adr, 16'h0000, rd);
	endtask

	////////////////////////////////////////
	// Row sequence

	task automatic apply_row(input vec_t v);
		word_t rd;
		ar_in = v.ar;
		wb_write(1'b0, 16'(CMD_FRAME_SIZE));
		wb_write(1'b1, 16'(v.width));
		wb_write(1'b1, 16'd88);
		wb_write(1'b1, 16'd44);
		wb_write(1'b1, 16'd148);
		wb_write(1'b1, 16'(v.height));
		wb_write(1'b1, 16'd4);
		wb_write(1'b1, 16'd5);
		wb_write(1'b1, 16'd36);
		wb_read(1'b1, rd);
		check_eq(rd, {4'h0, 4'd8, CMD_FRAME_SIZE}, "status after frame size");
		wb_write(1'b0, 16'(CMD_VSET));
		wb_write(1'b1, 16'(v.vset));
		wb_write(1'b0, 16'(CMD_HSET));
		wb_write(1'b1, {v.freescale, 3'b000, v.hset});
		wb_write(1'b0, 16'(CMD_CUSTOM_AR));
		wb_write(1'b1, {3'b000, v.ar1.x});
		wb_write(1'b1, {3'b000, v.ar1.y});
		wb_write(1'b1, {3'b000, v.ar2.x});
		wb_write(1'b1, {3'b000, v.ar2.y});
		wb_read(1'b0, rd);
		check_eq(rd, {4'h0, 4'd4, CMD_CUSTOM_AR}, "status after custom aspect");
	endtask

	// Active-low hsync and active-high vsync, both short pulses
	task automatic run_syncs();
		for (int c = 0; c < SYNC_CYCLES; c++) begin
			hs_in = (c % HS_PERIOD) >= HS_LOW;
			vs_in = (c % VS_PERIOD) < VS_HIGH;
			#4;
			if (c >= 3 * VS_PERIOD) begin
				check_eq(hs_out, (c % HS_PERIOD) < HS_LOW, "o_hs short active-high pulse");
				check_eq(vs_out, (c % VS_PERIOD) < VS_HIGH, "o_vs short active-high pulse");
			end
			@(posedge clk_sys);
			#1;
		end
	endtask

	initial begin
		vec_t  v;
		word_t rd;
		resetd = 1'b1;
		wb_req = '0;
		ar_in  = '0;
		hs_in  = 1'b1;
		vs_in  = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk_sys);
		#1;
		resetd = 1'b0;
		check_eq(win, 64'd0, "window zero after reset");
		check_eq(64'(wb_rsp.ack), 64'd0, "ack low after reset");

		// Default frame with no aspect
		wait_cycles(SETTLE_CYCLES);
		check_eq(win, {12'd0, 12'd1919, 12'd0, 12'd1079}, "default window");
		wb_read(1'b0, rd);
		check_eq(rd, 16'h0000, "status after reset");

		// Unknown command, index runs into its limit
		wb_write(1'b0, 16'h0055);
		for (int k = 0; k < 18; k++) begin
			wb_write(1'b1, 16'(k));
		end
		wb_read(1'b1, rd);
		check_eq(rd, {4'h0, 4'hF, 8'h55}, "index saturates at 15");

		for (int i = 0; i < N_VEC; i++) begin
			v = vec_row(i);
			apply_row(v);
			wait_cycles(SETTLE_CYCLES);
			check_eq(win, ref_window(v), $sformatf("window of table row %0d", i));
		end

		for (int r = 0; r < N_RAND; r++) begin
			v = vec_row(0);
			v.ar.x = 13'(1 + xorshift_next() % 63);
			v.ar.y = 13'(1 + xorshift_next() % 63);
			v.vset = 12'(540 + xorshift_next() % 540);
			apply_row(v);
			wait_cycles(SETTLE_CYCLES);
			check_eq(win, ref_window(v), $sformatf("window of random row %0d", r));
		end

		run_syncs();

		$display("Simulation completed successfully");
		$finish;
	end

endmodule

`default_nettype wire
